/* src.f */
+incdir+design
design/riscv_isa_pkg.sv
design/pipe_ifs.sv
design/register_file.sv
design/decode_stage.sv
design/forwarding_unit.sv
design/execution_stage.sv
design/retire_pipeline.sv
design/riscv_core.sv
test/tb_riscv_core.sv

/* Bender.yml */
package:
  name: riscv_core

sources:
  - include_dirs:
      - design
    files:
      - design/riscv_isa_pkg.sv
      - design/pipe_ifs.sv
      - design/register_file.sv
      - design/decode_stage.sv
      - design/forwarding_unit.sv
      - design/execution_stage.sv
      - design/retire_pipeline.sv
      - design/riscv_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_riscv_core.sv

/* test/tb_riscv_core.sv */
`timescale 1ns/100ps
`include "riscv_consts.svh"

module tb_riscv_core;

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 5;
    localparam int          OP_REPS      = 8;
    localparam int          CHAIN_LEN    = 6;
    localparam int          X0_ROUNDS    = 8;
    localparam int          RAND_COUNT   = 200;
    localparam int          DRAIN_LIMIT  = 12;
    localparam logic [31:0] LFSR_TAPS    = 32'h80200003;

    // Issued words, idle cycles and drain windows of all six tests
    localparam int ISSUE_COUNT = 1 + 62 + 20 * OP_REPS + 5 * CHAIN_LEN + 3 * X0_ROUNDS
                                 + RAND_COUNT;
    localparam int GAP_CYCLES  = 10 + 10 * CHAIN_LEN + 3 * RAND_COUNT;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + ISSUE_COUNT + GAP_CYCLES
                                    + 6 * (DRAIN_LIMIT + 1) + 20;

    logic                   clk;
    logic                   reset;
    logic                   instr_valid;
    logic [`XLEN-1:0]       instr;
    logic                   retire_valid;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic [`XLEN-1:0]       retire_data;

    logic [31:0]            lfsr_state;
    logic [`XLEN-1:0]       model_regs [`NUM_REGS];
    logic [`REG_ADDR_W-1:0] exp_rd_q [$];
    logic [`XLEN-1:0]       exp_data_q [$];
    logic [`REG_ADDR_W-1:0] exp_rd;
    logic [`XLEN-1:0]       exp_data;
    int                     checks;
    int                     errors;
    int                     last_checks;
    int                     last_errors;
    int                     cycle_count;

    riscv_core u_riscv_core (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped retiring", cycle_count);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Stimulus helpers

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    function automatic logic [4:0] any_reg();
        logic [31:0] bits;
        bits = lfsr_bits(5);
        return bits[4:0];
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [4:0] r;
        r = any_reg();
        return (r == '0) ? 5'd1 : r;
    endfunction

    // Ops 0 to 9 are R-type, 10 to 18 are I-type, 19 is LUI
    function automatic logic [31:0] encode_op(input int op, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [31:0] rnd);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        case (op)
            0, 1, 10:     f3 = `F3_ADD_SUB;
            2, 16:        f3 = `F3_SLL;
            3, 11:        f3 = `F3_SLT;
            4, 12:        f3 = `F3_SLTU;
            5, 13:        f3 = `F3_XOR;
            6, 7, 17, 18: f3 = `F3_SRL_SRA;
            8, 14:        f3 = `F3_OR;
            default:      f3 = `F3_AND;
        endcase
        f7 = (op == 1 || op == 7 || op == 18) ? 7'b0100000 : 7'b0000000;
        if (op < 10)
            return {f7, rs2, rs1, f3, rd, `OPC_OP};
        if (op == 19)
            return {rnd[19:0], rd, `OPC_LUI};
        imm12 = (f3 == `F3_SLL || f3 == `F3_SRL_SRA) ? {f7, rnd[4:0]} : rnd[11:0];
        return {imm12, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    // RV32I semantics applied to the model registers in program order
    function automatic logic [31:0] ref_execute(input logic [31:0] word);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        rd  = word[11:7];
        f3  = word[14:12];
        a   = model_regs[word[19:15]];
        alt = word[25 + `F7_ALT];
        if (word[6:0] == `OPC_OP) begin
            b = model_regs[word[24:20]];
        end else begin
            b   = {{20{word[31]}}, word[31:20]};
            alt = alt && (f3 == `F3_SRL_SRA);
        end
        case (f3)
            `F3_ADD_SUB: res = alt ? a - b : a + b;
            `F3_SLL:     res = a << b[4:0];
            `F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
            `F3_XOR:     res = a ^ b;
            `F3_OR:      res = a | b;
            `F3_AND:     res = a & b;
            default: begin
                if (alt)
                    res = $signed(a) >>> b[4:0];
                else
                    res = a >> b[4:0];
            end
        endcase
        if (word[6:0] == `OPC_LUI)
            res = {word[31:12], 12'b0};
        if (rd != 5'd0)
            model_regs[rd] = res;
        return res;
    endfunction

    task automatic issue(input logic [31:0] word);
        logic [31:0] result;
        result = ref_execute(word);
        // Only writing instructions report their rd and x0 writes report 0
        exp_rd_q.push_back(word[11:7]);
        exp_data_q.push_back(result);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic phase_done(input string name);
        int waited;
        waited = 0;
        idle_cycles(1);
        while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("%0d instructions of test %s never retired", exp_rd_q.size(), name);
            errors += exp_rd_q.size();
            exp_rd_q.delete();
            exp_data_q.delete();
        end
        $display("Test %s %4d retires checked, %0d errors", name, checks - last_checks,
                 errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    ////////////////////////////////////////
    // Tests

    task automatic check_latency();
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        @(negedge clk);
        if (retire_valid !== 1'b0) begin
            $display("CHECK FAILED at %0t: retire_valid %b after reset, expected 0", $time,
                     retire_valid);
            errors++;
        end
        issue(encode_op(10, 5'd1, 5'd0, 5'd0, 32'h0000_0abc));
        // The DUT samples the ADDI on this edge
        @(posedge clk);
        instr_valid <= 1'b0;
        while (!seen && edges < 20) begin
            @(negedge clk);
            if (retire_valid) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                edges++;
            end
        end
        if (!seen) begin
            $display("A single ADDI did not retire within 20 cycles");
            errors++;
        end else if (edges != 4) begin
            $display("CHECK FAILED at %0t: retire after edge %0d, expected edge 4", $time, edges);
            errors++;
        end
        @(posedge clk);
        @(negedge clk);
        if (retire_valid) begin
            $display("CHECK FAILED at %0t: retire_valid high for more than one cycle", $time);
            errors++;
        end
        phase_done("latency");
    endtask

    task automatic load_registers();
        logic [31:0] rnd;
        for (int r = 1; r < `NUM_REGS; r++) begin
            rnd = lfsr_bits(20);
            issue(encode_op(19, 5'(r), 5'd0, 5'd0, rnd));
            rnd = lfsr_bits(12);
            issue(encode_op(10, 5'(r), 5'(r), 5'd0, rnd));
        end
        phase_done("reg init");
    endtask

    task automatic sweep_alu_ops();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] rnd;
        for (int op = 0; op < 20; op++) begin
            for (int rep = 0; rep < OP_REPS; rep++) begin
                rd  = pick_reg();
                rs1 = any_reg();
                rs2 = any_reg();
                rnd = lfsr_bits(20);
                // First pass of each immediate shift uses the largest amount
                if (rep == 0)
                    rnd[4:0] = 5'd31;
                issue(encode_op(op, rd, rs1, rs2, rnd));
            end
        end
        phase_done("alu ops");
    endtask

    // Gaps 0 to 4 hit ex, dm1, dm2, wb and the write-through read
    task automatic forward_chains();
        int          op;
        logic [4:0]  prev;
        logic [4:0]  rd;
        logic [4:0]  other;
        logic [31:0] rnd;
        for (int gap = 0; gap <= 4; gap++) begin
            prev = pick_reg();
            for (int k = 0; k < CHAIN_LEN; k++) begin
                op    = lfsr_bits(5) % 19;
                rd    = pick_reg();
                other = any_reg();
                rnd   = lfsr_bits(20);
                issue(encode_op(op, rd, prev, (k % 2 == 1) ? prev : other, rnd));
                prev = rd;
                idle_cycles(gap);
            end
        end
        phase_done("forward");
    endtask

    task automatic x0_writes();
        int          op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] rnd;
        for (int round = 0; round < X0_ROUNDS; round++) begin
            op  = lfsr_bits(5) % 20;
            rs1 = any_reg();
            rs2 = any_reg();
            rnd = lfsr_bits(20);
            issue(encode_op(op, 5'd0, rs1, rs2, rnd));
            // Reads of x0 right behind the write still see zero
            rd  = pick_reg();
            rnd = lfsr_bits(12);
            issue(encode_op(10, rd, 5'd0, 5'd0, rnd));
            issue(encode_op(0, rd, 5'd0, 5'd0, 32'd0));
        end
        phase_done("x0");
    endtask

    task automatic random_program();
        int          op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] rnd;
        for (int i = 0; i < RAND_COUNT; i++) begin
            op  = lfsr_bits(5) % 20;
            rd  = any_reg();
            rs1 = any_reg();
            rs2 = any_reg();
            rnd = lfsr_bits(20);
            issue(encode_op(op, rd, rs1, rs2, rnd));
            if (lfsr_bits(2) == 0)
                idle_cycles(lfsr_bits(2));
        end
        phase_done("random");
    endtask

    ////////////////////////////////////////
    // Retire checker

    always @(negedge clk) begin
        if (!reset && retire_valid) begin
            checks++;
            if (exp_rd_q.size() == 0) begin
                $display("Retire at %0t with no instruction outstanding", $time);
                errors++;
            end else begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                if (retire_rd !== exp_rd) begin
                    $display("CHECK FAILED at %0t: retire_rd %0d, expected %0d", $time,
                             retire_rd, exp_rd);
                    errors++;
                end
                if (retire_data !== exp_data) begin
                    $display("CHECK FAILED at %0t: retire_data %h, expected %h", $time,
                             retire_data, exp_data);
                    errors++;
                end
            end
        end
    end

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr_state  = 32'd95639;
        checks      = 0;
        errors      = 0;
        last_checks = 0;
        last_errors = 0;
        for (int r = 0; r < `NUM_REGS; r++)
            model_regs[r] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        check_latency();
        load_registers();
        sweep_alu_ops();
        forward_chains();
        x0_writes();
        random_program();
        $display("Total: %0d retires checked, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* design/riscv_core.sv */
`timescale 1ns/100ps
`include "riscv_consts.svh"

module riscv_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  logic [`XLEN-1:0]       instr,
    output logic                   retire_valid,
    output logic [`REG_ADDR_W-1:0] retire_rd,
    output logic [`XLEN-1:0]       retire_data
);

    logic [`REG_ADDR_W-1:0] rf_rs1_addr;
    logic [`REG_ADDR_W-1:0] rf_rs2_addr;
    logic [`XLEN-1:0]       rf_rs1_data;
    logic [`XLEN-1:0]       rf_rs2_data;
    logic [`XLEN-1:0]       rs1_fwd;
    logic [`XLEN-1:0]       rs2_fwd;

    decode_exec_if  de_if ();
    stage_result_if ex_res ();
    stage_result_if dm1_res ();
    stage_result_if dm2_res ();
    stage_result_if wb_res ();

    decode_stage u_decode_stage (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rf_rs1_addr (rf_rs1_addr),
        .rf_rs2_addr (rf_rs2_addr),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .de          (de_if.producer)
    );

    // Write port fed from write-back
    register_file u_register_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rf_rs1_addr),
        .rs2_addr (rf_rs2_addr),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .wr_en    (wb_res.rd_we),
        .wr_addr  (wb_res.rd),
        .wr_data  (wb_res.data)
    );

    forwarding_unit u_forwarding_unit (
        .de      (de_if.consumer),
        .ex_res  (ex_res.sink),
        .dm1_res (dm1_res.sink),
        .dm2_res (dm2_res.sink),
        .wb_res  (wb_res.sink),
        .rs1_fwd (rs1_fwd),
        .rs2_fwd (rs2_fwd)
    );

    execution_stage u_execution_stage (
        .clk     (clk),
        .reset   (reset),
        .de      (de_if.consumer),
        .rs1_fwd (rs1_fwd),
        .rs2_fwd (rs2_fwd),
        .ex_res  (ex_res.source)
    );

    retire_pipeline u_retire_pipeline (
        .clk          (clk),
        .reset        (reset),
        .ex_res       (ex_res.sink),
        .dm1_res      (dm1_res.source),
        .dm2_res      (dm2_res.source),
        .wb_res       (wb_res.source),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

/* design/retire_pipeline.sv */
`timescale 1ns/100ps
`include "riscv_consts.svh"

module retire_pipeline (
    input  logic                   clk,
    input  logic                   reset,
    stage_result_if.sink           ex_res,
    stage_result_if.source         dm1_res,
    stage_result_if.source         dm2_res,
    stage_result_if.source         wb_res,
    output logic                   retire_valid,
    output logic [`REG_ADDR_W-1:0] retire_rd,
    output logic [`XLEN-1:0]       retire_data
);

    localparam int WB = `DM_STAGES - 1;

    // Stage 0 is DM1 and the last stage is write-back
    logic [`DM_STAGES-1:0]  valid_q;
    logic [`DM_STAGES-1:0]  rd_we_q;
    logic [`REG_ADDR_W-1:0] rd_q   [`DM_STAGES];
    logic [`XLEN-1:0]       data_q [`DM_STAGES];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            rd_we_q <= '0;
        end else begin
            valid_q <= {valid_q[`DM_STAGES-2:0], ex_res.valid};
            rd_we_q <= {rd_we_q[`DM_STAGES-2:0], ex_res.valid & ex_res.rd_we};
        end
    end

    always_ff @(posedge clk) begin
        rd_q[0]   <= ex_res.rd;
        data_q[0] <= ex_res.data;
        for (int i = 1; i < `DM_STAGES; i++) begin
            rd_q[i]   <= rd_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    // Every stage is visible to forwarding
    assign dm1_res.valid = valid_q[0];
    assign dm1_res.rd_we = rd_we_q[0];
    assign dm1_res.rd    = rd_q[0];
    assign dm1_res.data  = data_q[0];
    assign dm2_res.valid = valid_q[1];
    assign dm2_res.rd_we = rd_we_q[1];
    assign dm2_res.rd    = rd_q[1];
    assign dm2_res.data  = data_q[1];
    assign wb_res.valid  = valid_q[WB];
    assign wb_res.rd_we  = rd_we_q[WB];
    assign wb_res.rd     = rd_q[WB];
    assign wb_res.data   = data_q[WB];

    // Non-writing instructions report x0
    assign retire_valid = valid_q[WB];
    assign retire_rd    = rd_we_q[WB] ? rd_q[WB] : '0;
    assign retire_data  = data_q[WB];

endmodule

/* design/execution_stage.sv */
`timescale 1ns/100ps
`include "riscv_consts.svh"

module execution_stage (
    input  logic             clk,
    input  logic             reset,
    decode_exec_if.consumer  de,
    input  logic [`XLEN-1:0] rs1_fwd,
    input  logic [`XLEN-1:0] rs2_fwd,
    stage_result_if.source   ex_res
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [`XLEN-1:0]   operand_b;
    logic [SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0]   alu_result;

    assign operand_b = de.use_imm ? de.imm : rs2_fwd;
    assign shamt     = operand_b[SHAMT_W-1:0];

    ////////////////////////////////////////
    // ALU

    always_comb begin
        case (de.alu_op)
            `ALU_ADD:    alu_result = rs1_fwd + operand_b;
            `ALU_SUB:    alu_result = rs1_fwd - operand_b;
            `ALU_SLL:    alu_result = rs1_fwd << shamt;
            `ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(rs1_fwd) < $signed(operand_b)};
            `ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, rs1_fwd < operand_b};
            `ALU_XOR:    alu_result = rs1_fwd ^ operand_b;
            `ALU_SRL:    alu_result = rs1_fwd >> shamt;
            `ALU_SRA:    alu_result = $unsigned($signed(rs1_fwd) >>> shamt);
            `ALU_OR:     alu_result = rs1_fwd | operand_b;
            `ALU_AND:    alu_result = rs1_fwd & operand_b;
            `ALU_PASS_B: alu_result = operand_b;
            default:     alu_result = '0;
        endcase
    end

    ////////////////////////////////////////
    // Execute result register

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_res.valid <= 1'b0;
            ex_res.rd_we <= 1'b0;
        end else begin
            ex_res.valid <= de.valid;
            ex_res.rd_we <= de.valid & de.rd_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_res.rd   <= de.rd;
        ex_res.data <= alu_result;
    end

    // Decode must never hand over an op code outside the table
    a_alu_op_range : assert property (@(posedge clk) disable iff (reset)
        de.valid |-> (de.alu_op <= `ALU_PASS_B));

endmodule

/* design/forwarding_unit.sv */
`timescale 1ns/100ps
`include "riscv_consts.svh"

module forwarding_unit (
    decode_exec_if.consumer  de,
    stage_result_if.sink     ex_res,
    stage_result_if.sink     dm1_res,
    stage_result_if.sink     dm2_res,
    stage_result_if.sink     wb_res,
    output logic [`XLEN-1:0] rs1_fwd,
    output logic [`XLEN-1:0] rs2_fwd
);

    localparam int NUM_SRC = 4;

    // Index 0 is the youngest stage
    logic [NUM_SRC-1:0]     stage_we;
    logic [`REG_ADDR_W-1:0] stage_rd   [NUM_SRC];
    logic [`XLEN-1:0]       stage_data [NUM_SRC];

    assign stage_we[0]   = ex_res.valid & ex_res.rd_we;
    assign stage_rd[0]   = ex_res.rd;
    assign stage_data[0] = ex_res.data;
    assign stage_we[1]   = dm1_res.valid & dm1_res.rd_we;
    assign stage_rd[1]   = dm1_res.rd;
    assign stage_data[1] = dm1_res.data;
    assign stage_we[2]   = dm2_res.valid & dm2_res.rd_we;
    assign stage_rd[2]   = dm2_res.rd;
    assign stage_data[2] = dm2_res.data;
    assign stage_we[3]   = wb_res.valid & wb_res.rd_we;
    assign stage_rd[3]   = wb_res.rd;
    assign stage_data[3] = wb_res.data;

    // Walk from oldest to youngest so the newest match wins
    function automatic logic [`XLEN-1:0] newest(input logic [`REG_ADDR_W-1:0] src,
                                                 input logic [`XLEN-1:0]       rf_value);
        logic [`XLEN-1:0] value;
        value = rf_value;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if ((src != '0) && stage_we[i] && (stage_rd[i] == src)) begin
                value = stage_data[i];
            end
        end
        return value;
    endfunction

    always_comb begin
        rs1_fwd = newest(de.rs1_addr, de.rs1_data);
        rs2_fwd = newest(de.rs2_addr, de.rs2_data);
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/100ps
`include "riscv_consts.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  riscv_isa_pkg::instr_u  instr,
    output logic [`REG_ADDR_W-1:0] rf_rs1_addr,
    output logic [`REG_ADDR_W-1:0] rf_rs2_addr,
    input  logic [`XLEN-1:0]       rf_rs1_data,
    input  logic [`XLEN-1:0]       rf_rs2_data,
    decode_exec_if.producer        de
);
    import riscv_isa_pkg::*;

    logic [`ALU_OP_W-1:0]   alu_op;
    logic [`XLEN-1:0]       imm;
    logic                   use_imm;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   supported;

    function automatic logic [`ALU_OP_W-1:0] alu_op_of(input logic [2:0] funct3,
                                                        input logic       alt);
        logic [`ALU_OP_W-1:0] op;
        op = `ALU_ADD;
        case (funct3)
            `F3_ADD_SUB: op = alt ? `ALU_SUB : `ALU_ADD;
            `F3_SLL:     op = `ALU_SLL;
            `F3_SLT:     op = `ALU_SLT;
            `F3_SLTU:    op = `ALU_SLTU;
            `F3_XOR:     op = `ALU_XOR;
            `F3_SRL_SRA: op = alt ? `ALU_SRA : `ALU_SRL;
            `F3_OR:      op = `ALU_OR;
            `F3_AND:     op = `ALU_AND;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////
    // Field decode

    always_comb begin
        alu_op      = `ALU_ADD;
        imm         = '0;
        use_imm     = 1'b0;
        rd          = instr.r.rd;
        rf_rs1_addr = '0;
        rf_rs2_addr = '0;
        supported   = 1'b0;
        case (instr.r.opcode)
            `OPC_OP: begin
                supported   = 1'b1;
                rf_rs1_addr = instr.r.rs1;
                rf_rs2_addr = instr.r.rs2;
                alu_op      = alu_op_of(instr.r.funct3, instr.r.funct7[`F7_ALT]);
            end
            `OPC_OP_IMM: begin
                supported   = 1'b1;
                use_imm     = 1'b1;
                rd          = instr.i.rd;
                rf_rs1_addr = instr.i.rs1;
                imm         = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
                // Alt bit only counts for SRAI so a negative ADDI stays an add
                alu_op      = alu_op_of(instr.i.funct3,
                                        (instr.i.funct3 == `F3_SRL_SRA) &&
                                        instr.i.imm12[`F7_ALT + 5]);
            end
            `OPC_LUI: begin
                supported = 1'b1;
                use_imm   = 1'b1;
                rd        = instr.u.rd;
                imm       = {instr.u.imm20, 12'b0};
                alu_op    = `ALU_PASS_B;
            end
            default: supported = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Decode register

    always_ff @(posedge clk) begin
        if (reset) begin
            de.valid <= 1'b0;
            de.rd_we <= 1'b0;
        end else begin
            de.valid <= instr_valid;
            de.rd_we <= instr_valid && supported && (rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            de.alu_op   <= alu_op;
            de.rs1_addr <= rf_rs1_addr;
            de.rs2_addr <= rf_rs2_addr;
            de.rs1_data <= rf_rs1_data;
            de.rs2_data <= rf_rs2_data;
            de.imm      <= imm;
            de.use_imm  <= use_imm;
            de.rd       <= rd;
        end
    end

    a_supported_opcode : assert property (@(posedge clk) disable iff (reset)
        instr_valid |-> supported);

endmodule

/* design/register_file.sv */
`timescale 1ns/100ps
`include "riscv_consts.svh"

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`XLEN-1:0]       wr_data
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];
    logic             rs1_hit;
    logic             rs2_hit;

    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so decode sees the value retiring in this cycle
    assign rs1_hit = wr_en && (wr_addr != '0) && (wr_addr == rs1_addr);
    assign rs2_hit = wr_en && (wr_addr != '0) && (wr_addr == rs2_addr);

    always_comb begin
        if (rs1_hit) begin
            rs1_data = wr_data;
        end else if (rs1_addr == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end

        if (rs2_hit) begin
            rs2_data = wr_data;
        end else if (rs2_addr == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

    // The bypass path must not leak a write aimed at x0
    a_x0_reads_zero : assert property (@(posedge clk) disable iff (reset)
        ((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0)));

endmodule

/* design/pipe_ifs.sv */
`timescale 1ns/100ps
`include "riscv_consts.svh"

// Decode register contents as seen by execute and forwarding
interface decode_exec_if;
    logic                   valid;
    logic [`ALU_OP_W-1:0]   alu_op;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
    logic                   use_imm;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_we;

    modport producer (
        output valid, alu_op, rs1_addr, rs2_addr, rs1_data, rs2_data,
        output imm, use_imm, rd, rd_we
    );

    modport consumer (
        input valid, alu_op, rs1_addr, rs2_addr, rs1_data, rs2_data,
        input imm, use_imm, rd, rd_we
    );
endinterface

// Result held by one in-flight stage from execute to write-back
interface stage_result_if;
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_we;
    logic [`XLEN-1:0]       data;

    modport source (output valid, rd, rd_we, data);
    modport sink   (input  valid, rd, rd_we, data);
endinterface

/* design/riscv_isa_pkg.sv */
`include "riscv_consts.svh"

package riscv_isa_pkg;

    // One 32-bit instruction word seen through the R, I and U formats
    typedef union packed {
        struct packed {
            logic [6:0]             funct7;
            logic [`REG_ADDR_W-1:0] rs2;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } r;
        struct packed {
            logic [11:0]            imm12;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } i;
        struct packed {
            logic [19:0]            imm20;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } u;
    } instr_u;

endpackage

/* design/riscv_consts.svh */
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// Datapath and register file geometry
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// ALU operation codes
`define ALU_OP_W    4
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLL     4'd2
`define ALU_SLT     4'd3
`define ALU_SLTU    4'd4
`define ALU_XOR     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_OR      4'd8
`define ALU_AND     4'd9
`define ALU_PASS_B  4'd10

// Major opcodes handled by this core
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

// funct3 encodings shared by OP and OP-IMM
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// Bit index inside funct7 that selects SUB and SRA
`define F7_ALT      5

// Data-memory stages after execute with write-back as the last one
`define DM_STAGES   3

`endif
